// ==== adpcm.f ====
+incdir+rtl
rtl/adpcm_pkg.sv
rtl/adpcm_step_pipe.sv
rtl/adpcm_chan_seq.sv
rtl/adpcm_mixer.sv
rtl/adpcm_top.sv
verif/tb_adpcm_top.sv

// ==== Makefile ====
# Verilator build and run of the ADPCM-B decoder testbench

VERILATOR ?= verilator
TOP       ?= tb_adpcm_top
FILELIST  ?= adpcm.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_adpcm_top.sv ====
// ----------------------------------------------------------
// Testbench for the six-channel ADPCM-B decoder
// Applies a table of per-frame channel codes through the host
// write port, checks every chan_out and every frame mix
// against a reference model of the decode and mix rules
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "adpcm_params.svh"

module tb_adpcm_top;

    localparam int NCH   = `ADPCM_CHANNELS;
    localparam int CHW   = `ADPCM_CHW;
    localparam int DIV   = `ADPCM_CEN_DIV;
    localparam int NROWS = 10;

    localparam logic [1:0] CHK_NONE   = 2'd0;
    localparam logic [1:0] CHK_SAMPLE = 2'd1;  // Last channel 0 sample
    localparam logic [1:0] CHK_MIX    = 2'd2;  // Last frame mix
    localparam logic [1:0] CHK_FLOOR  = 2'd3;  // Channel 0 change per frame

    typedef struct packed {
        logic [2:0]  test;
        logic [7:0]  reps;   // Frames the row is held
        logic        rnd;    // Random code bits, on bits kept
        logic [29:0] codes;  // {ch5 .. ch0}, each {on, code}
        logic [1:0]  chk;
        logic [15:0] val;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    logic                 wr;
    logic [CHW-1:0]       wr_chan;
    logic [4:0]           wr_code;
    logic                 frame_start;
    adpcm_pkg::chan_out_t chan_out;
    adpcm_pkg::sample_t   mix;
    logic                 mix_valid;

    row_t                 rows [NROWS];
    string                test_names [6] = '{"reset state", "step growth",
        "step floor and negative limit", "channel off", "channel independence",
        "mix saturation"};
    logic [4:0]           host_reg [NCH];  // Mirror of host writes
    int                   x_m [NCH];       // Model samples
    int                   step_m [NCH];    // Model steps
    adpcm_pkg::chan_out_t exp_q [$];       // Results still inside the ring
    int                   seen [NCH];      // Last DUT sample per channel
    int                   prev [NCH];
    int                   model_slot = 0;
    int                   phase = -1;      // Negedges since last tick
    int                   acc_m = 0;
    int                   mix_exp = 0;
    bit                   mix_due = 1'b0;
    int                   last_mix = 0;
    int                   seed = 32'h52e7_0e03;
    int                   cycles = 0;
    int                   limit = 0;
    int                   checks = 0;
    int                   errors = 0;

    adpcm_top adpcm_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (wr),
        .wr_chan     (wr_chan),
        .wr_code     (wr_code),
        .frame_start (frame_start),
        .chan_out    (chan_out),
        .mix         (mix),
        .mix_valid   (mix_valid)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    function automatic int clip(input int v, input int lo, input int hi);
        if (v > hi)
            return hi;
        else if (v < lo)
            return lo;
        return v;
    endfunction

    // One channel tick, result queued for chan_out five ticks on
    function automatic void decode(input int c, input logic [4:0] r);
        int                   mag;
        int                   fac;
        int                   off;
        adpcm_pkg::chan_out_t e;
        mag = 2 * int'(r[2:0]) + 1;      // Odd magnitude 1..15
        case (r[2:0])
            3'd4:    fac = 77;
            3'd5:    fac = 102;
            3'd6:    fac = 128;
            3'd7:    fac = 153;
            default: fac = 57;
        endcase
        off = (mag * step_m[c]) / 8;
        if (r[4]) begin
            x_m[c]    = clip(r[3] ? x_m[c] - off : x_m[c] + off, -32768, 32767);
            step_m[c] = clip((fac * step_m[c]) / 64, `ADPCM_STEP_MIN, `ADPCM_STEP_MAX);
        end else begin
            x_m[c]    = 0;               // Off channel cleared
            step_m[c] = 0;
        end
        e.sample = 16'(x_m[c]);
        e.chan   = CHW'(c);
        e.valid  = 1'b1;
        exp_q.push_back(e);
    endfunction

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] expv);
        checks++;
        assert (got == expv) else begin
            $display("Error: %s = %h expected %h", name, got, expv);
            errors++;
        end
    endtask

    // Host register mirror and run limit
    always @(posedge clk) begin
        if (rst_n && wr && int'(wr_chan) < NCH)
            host_reg[wr_chan] = wr_code;
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout: run did not end within %0d cycles", limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // Scoreboard, tick timing taken from frame_start
    always @(negedge clk) begin
        adpcm_pkg::chan_out_t exp_o;
        bit                   tick;
        checks++;
        assert (mix_valid == mix_due) else begin
            $display("Error: mix_valid = %h expected %h", mix_valid, mix_due);
            errors++;
        end
        if (mix_due && mix_valid) begin
            checks++;
            assert (mix == 16'(mix_exp)) else begin
                $display("Error: mix = %h expected %h", mix, 16'(mix_exp));
                errors++;
            end
            last_mix = int'(mix);
        end
        mix_due = 1'b0;
        if (phase >= 0)
            phase++;
        tick = (phase == DIV) || (phase < 0 && frame_start);
        if (tick)
            phase = 0;
        checks++;
        assert (frame_start == (tick && model_slot == 0)) else begin
            $display("Error: frame_start = %h expected %h", frame_start,
                     tick && model_slot == 0);
            errors++;
        end
        if (tick) begin
            checks++;
            if (exp_q.size() == NCH) begin
                exp_o = exp_q.pop_front();
                assert (chan_out == exp_o) else begin
                    $display("Error: chan_out sample/chan = %h/%h expected %h/%h",
                             chan_out.sample, chan_out.chan, exp_o.sample, exp_o.chan);
                    errors++;
                end
                prev[exp_o.chan] = seen[exp_o.chan];
                seen[exp_o.chan] = int'(chan_out.sample);
                acc_m += int'(exp_o.sample);
                if (int'(exp_o.chan) == NCH - 1) begin
                    mix_exp = clip(acc_m, -32768, 32767);  // Frame complete
                    acc_m   = 0;
                    mix_due = 1'b1;
                end
            end else begin
                assert (!chan_out.valid) else begin
                    $display("Error: chan_out.valid = %h expected 0", chan_out.valid);
                    errors++;
                end
            end
            decode(model_slot, host_reg[model_slot]);
            model_slot = (model_slot + 1) % NCH;
        end
    end

    initial begin
        int         total;
        int         test_err0;
        int         last_test;
        int         failed_tests;
        bit         test_done;
        logic [4:0] code;
        // test, frames, random, codes ch5..ch0, check, value
        rows[0] = '{3'd1, 8'd2,  1'b0, {6{5'h00}}, CHK_NONE, 16'h0000};
        rows[1] = '{3'd2, 8'd12, 1'b0, {{5{5'h00}}, 5'h17}, CHK_SAMPLE, 16'h7FFF};
        rows[2] = '{3'd3, 8'd55, 1'b0, {{5{5'h00}}, 5'h18}, CHK_FLOOR, 16'hFFF1};  // -127/8
        rows[3] = '{3'd3, 8'd12, 1'b0, {{5{5'h00}}, 5'h1F}, CHK_SAMPLE, 16'h8000};
        rows[4] = '{3'd4, 8'd3,  1'b0, {{4{5'h00}}, 5'h12, 5'h07}, CHK_SAMPLE, 16'h0000};
        rows[5] = '{3'd4, 8'd4,  1'b0, {{4{5'h00}}, 5'h12, 5'h12}, CHK_NONE, 16'h0000};
        rows[6] = '{3'd5, 8'd20, 1'b1, {6{5'h10}}, CHK_NONE, 16'h0000};
        rows[7] = '{3'd6, 8'd14, 1'b0, {6{5'h17}}, CHK_MIX, 16'h7FFF};
        rows[8] = '{3'd6, 8'd6,  1'b0, {6{5'h1F}}, CHK_MIX, 16'h8000};
        rows[9] = '{3'd6, 8'd6,  1'b0, {{3{5'h1F}}, {3{5'h17}}}, CHK_MIX, 16'hFFFD};
        rst_n   = 1'b0;
        wr      = 1'b0;
        wr_chan = '0;
        wr_code = '0;
        for (int c = 0; c < NCH; c++) begin
            host_reg[c] = '0;
            x_m[c]      = 0;
            step_m[c]   = 0;
            seen[c]     = 0;
            prev[c]     = 0;
        end
        total = 0;
        foreach (rows[r])
            total += int'(rows[r].reps);
        limit        = total * NCH * DIV + 200;
        failed_tests = 0;
        test_err0    = errors;
        last_test    = 1;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        // Idle outputs straight out of reset
        check_word("chan_out.sample", chan_out.sample, 16'h0000);
        check_word("chan_out.valid", 16'(chan_out.valid), 16'h0000);
        check_word("mix", mix, 16'h0000);
        check_word("frame_start", 16'(frame_start), 16'h0000);
        for (int r = 0; r < NROWS; r++) begin
            if (int'(rows[r].test) != last_test) begin
                test_err0 = errors;
                last_test = int'(rows[r].test);
            end
            for (int f = 0; f < int'(rows[r].reps); f++) begin
                do
                    @(negedge clk);
                while (!frame_start);
                for (int c = 0; c < NCH; c++) begin
                    code = rows[r].codes[5*c +: 5];
                    if (rows[r].rnd)
                        code[3:0] = 4'($random(seed));
                    wr      = 1'b1;
                    wr_chan = CHW'(c);
                    wr_code = code;
                    @(negedge clk);
                end
                wr = 1'b0;
            end
            if (r == NROWS - 1)
                repeat (2 * NCH * DIV) @(negedge clk);  // Drain the ring
            @(posedge clk);
            case (rows[r].chk)
                CHK_SAMPLE: check_word("chan_out.sample ch0", 16'(seen[0]), rows[r].val);
                CHK_MIX:    check_word("mix", 16'(last_mix), rows[r].val);
                CHK_FLOOR:  check_word("chan_out.sample ch0 change",
                                       16'(seen[0] - prev[0]), rows[r].val);
                default:    ;
            endcase
            if (r == NROWS - 1)
                test_done = 1'b1;
            else
                test_done = (rows[r + 1].test != rows[r].test);
            if (test_done) begin
                if (errors != test_err0)
                    failed_tests++;
                $display("Test %0d %s: %s", last_test, test_names[last_test - 1],
                         (errors == test_err0) ? "ok" : "FAILED");
            end
        end
        $display("Tests: 6, failed tests: %0d, checks: %0d, errors: %0d",
                 failed_tests, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/adpcm_top.sv ====
// ----------------------------------------------------------
// Six-channel ADPCM-B decoder top level
// Host writes per-channel codes; decoded samples come out
// per channel and as a saturated frame mix
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "adpcm_params.svh"

module adpcm_top (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  wr,
    input  wire [`ADPCM_CHW-1:0] wr_chan,
    input  wire [4:0]            wr_code,      // {on, code[3:0]}
    output wire                  frame_start,
    output adpcm_pkg::chan_out_t chan_out,
    output adpcm_pkg::sample_t   mix,
    output wire                  mix_valid
);

    wire                   cen;
    wire adpcm_pkg::slot_t slot;

    // Clock enable, slot order and host registers
    adpcm_chan_seq adpcm_chan_seq_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (wr),
        .wr_chan     (wr_chan),
        .wr_code     (wr_code),
        .cen         (cen),
        .frame_start (frame_start),
        .slot        (slot)
    );

    // Shared decode ring
    adpcm_step_pipe adpcm_step_pipe_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .slot     (slot),
        .chan_out (chan_out)
    );

    adpcm_mixer adpcm_mixer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .chan_out  (chan_out),   // Also a top-level output
        .mix       (mix),
        .mix_valid (mix_valid)
    );

endmodule

`default_nettype wire

// ==== rtl/adpcm_mixer.sv ====
// ----------------------------------------------------------
// Frame mixer for the ADPCM-B decoder
// Sums the six channel samples of a frame, saturates to
// 16 bits and flags the result with a one-cycle mix_valid
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "adpcm_params.svh"

module adpcm_mixer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       cen,
    input  wire adpcm_pkg::chan_out_t chan_out,
    output adpcm_pkg::sample_t        mix,
    output logic                      mix_valid
);

    localparam int XW  = `ADPCM_XW;
    localparam int CHW = `ADPCM_CHW;
    localparam int AW  = XW + 3;    // Room for six full-scale samples

    localparam logic signed [AW-1:0] SUM_MAX = {{(AW-XW+1){1'b0}}, {(XW-1){1'b1}}};
    localparam logic signed [AW-1:0] SUM_MIN = {{(AW-XW+1){1'b1}}, {(XW-1){1'b0}}};

    logic signed [AW-1:0] acc;      // Running frame sum
    logic signed [AW-1:0] sum;
    logic                 last_chan;
    adpcm_pkg::sample_t   sum_sat;

    assign sum = acc + {{(AW-XW){chan_out.sample[XW-1]}}, chan_out.sample};

    assign last_chan = chan_out.valid && (chan_out.chan == CHW'(`ADPCM_CHANNELS - 1));

    always_comb begin
        if (sum > SUM_MAX)
            sum_sat = SUM_MAX[XW-1:0];  // Positive clip
        else if (sum < SUM_MIN)
            sum_sat = SUM_MIN[XW-1:0];  // Negative clip
        else
            sum_sat = sum[XW-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            mix       <= '0;
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= 1'b0;                  // Single clk pulse
            if (cen && chan_out.valid) begin
                if (last_chan) begin
                    mix       <= sum_sat;
                    mix_valid <= 1'b1;
                    acc       <= '0;            // Next frame starts clean
                end else begin
                    acc <= sum;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/adpcm_chan_seq.sv ====
// ----------------------------------------------------------
// Channel sequencer for the ADPCM-B decode ring
// Divides clk into cen, walks slots 0..5 and presents each
// channel's host-written code and on bit on its tick
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "adpcm_params.svh"

module adpcm_chan_seq (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  wr,
    input  wire [`ADPCM_CHW-1:0] wr_chan,
    input  wire [4:0]            wr_code,      // {on, code[3:0]}
    output logic                 cen,
    output logic                 frame_start,
    output adpcm_pkg::slot_t     slot
);

    localparam int CHW  = `ADPCM_CHW;
    localparam int DIVW = (`ADPCM_CEN_DIV > 1) ? $clog2(`ADPCM_CEN_DIV) : 1;

    logic [DIVW-1:0] div_cnt;
    logic            div_last;
    logic [CHW-1:0]  slot_cnt;
    logic [4:0]      chan_reg [`ADPCM_CHANNELS];  // Host view of each channel
    logic [4:0]      cur_reg;

    assign div_last = (div_cnt == DIVW'(`ADPCM_CEN_DIV - 1));

    // Enable divider, cen registered so it is glitch free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            cen     <= 1'b0;
        end else begin
            cen <= div_last;
            if (div_last)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    // Slot counter, moves on each tick and wraps at the last channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt <= '0;
        end else if (cen) begin
            if (slot_cnt == CHW'(`ADPCM_CHANNELS - 1))
                slot_cnt <= '0;
            else
                slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // Host writes, out of range index dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ADPCM_CHANNELS; i++)
                chan_reg[i] <= '0;               // All channels off
        end else if (wr && (wr_chan <= CHW'(`ADPCM_CHANNELS - 1))) begin
            chan_reg[wr_chan] <= wr_code;
        end
    end

    // Read through, so a write lands on the channel's very next tick
    assign cur_reg = chan_reg[slot_cnt];

    always_comb begin
        slot.code = cur_reg[3:0];
        slot.on   = cur_reg[4];
        slot.chan = slot_cnt;
    end

    assign frame_start = cen && (slot_cnt == '0);  // Slot 0 entering

endmodule

`default_nettype wire

// ==== rtl/adpcm_step_pipe.sv ====
// ----------------------------------------------------------
// Six-stage ADPCM-B decode ring shared by all channels
// One code enters per cen tick; its result shows on chan_out
// five ticks later and re-enters stage I on the next slot
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "adpcm_params.svh"

module adpcm_step_pipe (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cen,
    input  wire adpcm_pkg::slot_t slot,
    output adpcm_pkg::chan_out_t  chan_out
);

    localparam int XW  = `ADPCM_XW;
    localparam int STW = `ADPCM_STEPW;
    localparam int CHW = `ADPCM_CHW;

    // Sample limits at the stage III width
    localparam logic signed [XW+1:0] X4_MAX = {3'b000, {(XW-1){1'b1}}};
    localparam logic signed [XW+1:0] X4_MIN = {3'b111, {(XW-1){1'b0}}};

    // Stage I outputs
    logic [3:0]          mag2;   // Odd magnitude 1..15
    logic                sign2;
    adpcm_pkg::sample_t  x2;
    adpcm_pkg::step_t    step2;
    logic                on2;
    logic [CHW-1:0]      ch2;
    logic                v2;

    // Stage II outputs
    logic [STW:0]        off3;   // Offset, step*mag/8
    logic                sign3;
    adpcm_pkg::sample_t  x3;
    logic [STW+1:0]      step3;  // Unclamped next step
    logic                on3;
    logic [CHW-1:0]      ch3;
    logic                v3;

    // Stage III outputs
    logic signed [XW+1:0] x4;    // Two guard bits
    logic [STW+1:0]       step4;
    logic                 on4;
    logic [CHW-1:0]       ch4;
    logic                 v4;

    // Stage IV to VI, ring closes at x1/step1
    adpcm_pkg::sample_t  x5, x6, x1;
    adpcm_pkg::step_t    step5, step6, step1;
    logic [CHW-1:0]      ch5, ch6, ch1;
    logic                v5, v6, v1;

    // Stage II arithmetic
    logic [7:0]          step_fac;
    logic [STW+3:0]      off_prod;   // 4 x 15 bits
    logic [STW+7:0]      step_prod;  // 8 x 15 bits

    // Stage III operands
    logic signed [XW+1:0] x3_ext;
    logic signed [XW+1:0] off3_ext;

    always_comb begin
        // Step factor picked by code magnitude
        casez (mag2[3:1])
            3'b0??:  step_fac = 8'd57;
            3'b100:  step_fac = 8'd77;
            3'b101:  step_fac = 8'd102;
            3'b110:  step_fac = 8'd128;
            default: step_fac = 8'd153;
        endcase
        off_prod  = mag2 * step2;
        step_prod = step_fac * step2;
    end

    assign x3_ext   = {{2{x3[XW-1]}}, x3};          // Sign extend
    assign off3_ext = {{(XW+1-STW){1'b0}}, off3};   // Offset is unsigned

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mag2  <= '0;
            sign2 <= 1'b0;
            x2    <= '0;
            step2 <= '0;
            on2   <= 1'b0;
            ch2   <= '0;
            v2    <= 1'b0;
            off3  <= '0;
            sign3 <= 1'b0;
            x3    <= '0;
            step3 <= '0;
            on3   <= 1'b0;
            ch3   <= '0;
            v3    <= 1'b0;
            x4    <= '0;
            step4 <= '0;
            on4   <= 1'b0;
            ch4   <= '0;
            v4    <= 1'b0;
            x5    <= '0;
            step5 <= '0;
            ch5   <= '0;
            v5    <= 1'b0;
            x6    <= '0;
            step6 <= '0;
            ch6   <= '0;
            v6    <= 1'b0;
            x1    <= '0;
            step1 <= '0;
            ch1   <= '0;
            v1    <= 1'b0;
        end else if (cen) begin
            // I  new code meets the channel's looped state
            mag2  <= {slot.code[2:0], 1'b1};
            sign2 <= slot.code[3];
            x2    <= x1;
            step2 <= step1;
            on2   <= slot.on;
            ch2   <= slot.chan;
            v2    <= 1'b1;

            // II  offset and next step
            off3  <= off_prod[STW+3:3];    // Divide by 8
            sign3 <= sign2;
            x3    <= x2;
            step3 <= step_prod[STW+7:6];   // Divide by 64
            on3   <= on2;
            ch3   <= ch2;
            v3    <= v2;

            // III
            x4    <= sign3 ? (x3_ext - off3_ext) : (x3_ext + off3_ext);
            step4 <= step3;
            on4   <= on3;
            ch4   <= ch3;
            v4    <= v3;

            // IV  limits, off channel resets to zero
            if (on4) begin
                if (x4 > X4_MAX)
                    x5 <= X4_MAX[XW-1:0];  // 16'h7FFF
                else if (x4 < X4_MIN)
                    x5 <= X4_MIN[XW-1:0];  // 16'h8000
                else
                    x5 <= x4[XW-1:0];

                if (step4 < (STW+2)'(`ADPCM_STEP_MIN))
                    step5 <= STW'(`ADPCM_STEP_MIN);
                else if (step4 > (STW+2)'(`ADPCM_STEP_MAX))
                    step5 <= STW'(`ADPCM_STEP_MAX);
                else
                    step5 <= step4[STW-1:0];
            end else begin
                x5    <= '0;
                step5 <= '0;
            end
            ch5   <= ch4;
            v5    <= v4;

            // V  pad
            x6    <= x5;
            step6 <= step5;
            ch6   <= ch5;
            v6    <= v5;

            // VI  back round to stage I
            x1    <= x6;
            step1 <= step6;
            ch1   <= ch6;
            v1    <= v6;
        end
    end

    always_comb begin
        chan_out.sample = x1;
        chan_out.chan   = ch1;   // Index rode along with the data
        chan_out.valid  = v1;
    end

endmodule

`default_nettype wire

// ==== rtl/adpcm_pkg.sv ====
// ----------------------------------------------------------
// Shared types for the ADPCM-B decoder
// Slot and channel output structs, used by RTL and testbench
// through scoped names
// ----------------------------------------------------------
`default_nettype none

`include "adpcm_params.svh"

package adpcm_pkg;

    // Decoded sample, two's complement
    typedef logic signed [`ADPCM_XW-1:0] sample_t;

    // Adaptive step size, always positive
    typedef logic [`ADPCM_STEPW-1:0] step_t;

    // Channel entering stage I on a cen tick
    typedef struct packed {
        logic [3:0]            code;  // Bit 3 sign, bits 2:0 magnitude
        logic                  on;    // Channel enabled
        logic [`ADPCM_CHW-1:0] chan;  // Slot index
    } slot_t;

    // Decoded sample leaving the ring
    typedef struct packed {
        sample_t               sample;
        logic [`ADPCM_CHW-1:0] chan;   // Owner of this sample
        logic                  valid;  // Low until the ring has filled
    } chan_out_t;

endpackage

`default_nettype wire

// ==== rtl/adpcm_params.svh ====
// ----------------------------------------------------------
// Build constants for the six-channel ADPCM-B decoder
// Include in any RTL or testbench file that sizes its logic
// from the channel count, sample width or step limits
// ----------------------------------------------------------
`ifndef ADPCM_PARAMS_SVH
`define ADPCM_PARAMS_SVH

// Channel count, equal to the decode ring depth
`define ADPCM_CHANNELS 6

// Width of a channel index
`define ADPCM_CHW 3

// Sample and step widths
`define ADPCM_XW 16
`define ADPCM_STEPW 15

// Step size limits applied in stage IV
`define ADPCM_STEP_MIN 127
`define ADPCM_STEP_MAX 24576

// clk cycles per enable tick
`define ADPCM_CEN_DIV 4

`endif
